/* design/colmix_pkg.sv */
// colour mixer shared constants
package colmix_pkg;

    // pixel and palette geometry
    localparam int pxl_w = 8;
    // layer code sits above the pixel value
    localparam int pal_aw = 10;

    // priority prom shape
    localparam int prom_aw = 10;
    localparam int prom_dw = 2;

    // layer codes, also the prom output meaning
    localparam logic [1:0] layer_ba0 = 2'd0;
    localparam logic [1:0] layer_obj = 2'd1;
    localparam logic [1:0] layer_ba1 = 2'd2;
    localparam logic [1:0] layer_ba2 = 2'd3;

    // scene select width
    localparam int prisel_w = 3;

    // priority address field positions
    localparam int sel_prisel_lo = 7;
    localparam int sel_ba0_tr = 6;
    localparam int sel_obj_msb = 5;
    localparam int sel_obj_tr = 4;
    localparam int sel_ba1_msb = 3;
    localparam int sel_ba1_b3 = 2;
    localparam int sel_ba1_tr = 1;
    localparam int sel_ba2_tr = 0;

    // output delay in pixel enables
    localparam int blank_dly = 2;
    // green, red, blue packed
    localparam int rgb_w = 3 * pxl_w;

endpackage

/* design/prio_prom.sv */
// priority prom
`timescale 1ns/1ns

module prio_prom (
    input  logic                           clk,
    input  logic [colmix_pkg::prom_aw-1:0] rd_addr,
    input  logic [colmix_pkg::prom_aw-1:0] wr_addr,
    input  logic [colmix_pkg::prom_dw-1:0] wr_data,
    input  logic                           we,
    output logic [colmix_pkg::prom_dw-1:0] q
);

    localparam int depth = 2 ** colmix_pkg::prom_aw;

    // register file, contents undefined until loaded
    logic [colmix_pkg::prom_dw-1:0] mem [depth];

    // loader port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read
    // one clk from address to layer code
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

/* design/pal_ram.sv */
// palette memories
`timescale 1ns/1ns

module pal_ram (
    input  logic                          clk,

    // cpu side
    input  logic [colmix_pkg::pal_aw-1:0] cpu_addr,
    input  logic [15:0]                   cpu_data,
    input  logic [1:0]                    we_gr,
    input  logic                          we_b,
    output logic [15:0]                   cpu_gr,
    output logic [7:0]                    cpu_b,

    // video side
    input  logic [colmix_pkg::pal_aw-1:0] vid_addr,
    output logic [15:0]                   vid_gr,
    output logic [7:0]                    vid_b
);

    localparam int depth = 2 ** colmix_pkg::pal_aw;

    // green in the upper byte, red in the lower
    logic [15:0] gr_mem [depth];
    logic [7:0]  b_mem  [depth];

    // red-green writes, one lane per enable
    always_ff @(posedge clk) begin
        if (we_gr[0]) begin
            gr_mem[cpu_addr][7:0] <= cpu_data[7:0];
        end
        if (we_gr[1]) begin
            gr_mem[cpu_addr][15:8] <= cpu_data[15:8];
        end
    end

    // blue writes take the low data byte
    always_ff @(posedge clk) begin
        if (we_b) begin
            b_mem[cpu_addr] <= cpu_data[7:0];
        end
    end

    // cpu readback
    // old data returned on a same-cycle write
    always_ff @(posedge clk) begin
        cpu_gr <= gr_mem[cpu_addr];
        cpu_b  <= b_mem[cpu_addr];
    end

    // video read, every clk
    always_ff @(posedge clk) begin
        vid_gr <= gr_mem[vid_addr];
        vid_b  <= b_mem[vid_addr];
    end

endmodule

/* design/blank_delay.sv */
// blanking and colour delay
`timescale 1ns/1ns

module blank_delay (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pxl_cen,
    input  logic                         lhbl,
    input  logic                         lvbl,
    input  logic [colmix_pkg::rgb_w-1:0] rgb_in,
    output logic                         lhbl_dly,
    output logic                         lvbl_dly,
    output logic [colmix_pkg::rgb_w-1:0] rgb_out
);

    localparam int depth = colmix_pkg::blank_dly;

    // stage 0 takes the inputs, last stage drives the outputs
    logic [depth-1:0]               hbl_sr;
    logic [depth-1:0]               vbl_sr;
    logic [colmix_pkg::rgb_w-1:0]   rgb_sr [depth];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // all stages blanked, colour black
            hbl_sr <= '0;
            vbl_sr <= '0;
            for (int i = 0; i < depth; i++) begin
                rgb_sr[i] <= '0;
            end
        end else if (pxl_cen) begin
            hbl_sr <= {hbl_sr[depth-2:0], lhbl};
            vbl_sr <= {vbl_sr[depth-2:0], lvbl};
            rgb_sr[0] <= rgb_in;
            for (int i = 1; i < depth - 1; i++) begin
                rgb_sr[i] <= rgb_sr[i-1];
            end
            // black while the entering stage is blanked
            rgb_sr[depth-1] <= (hbl_sr[depth-2] && vbl_sr[depth-2]) ?
                               rgb_sr[depth-2] : '0;
        end
    end

    assign lhbl_dly = hbl_sr[depth-1];
    assign lvbl_dly = vbl_sr[depth-1];
    assign rgb_out  = rgb_sr[depth-1];

endmodule

/* design/colmix.sv */
// colour mixer top
`timescale 1ns/1ns

module colmix (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pxl_cen,
    input  logic                            lhbl,
    input  logic                            lvbl,

    // cpu palette port
    input  logic [1:0]                      pal_cs,
    input  logic [9:0]                      cpu_addr,
    input  logic [15:0]                     cpu_dout,
    input  logic [1:0]                      dsn,
    output logic [15:0]                     cpu_din,

    // priority scene and prom loader
    input  logic [colmix_pkg::prisel_w-1:0] prisel,
    input  logic [colmix_pkg::prom_aw-1:0]  prog_addr,
    input  logic [colmix_pkg::prom_dw-1:0]  prom_din,
    input  logic                            prom_we,

    // layer pixels
    input  logic [colmix_pkg::pxl_w-1:0]    ba0_pxl,
    input  logic [colmix_pkg::pxl_w-1:0]    ba1_pxl,
    input  logic [colmix_pkg::pxl_w-1:0]    ba2_pxl,
    input  logic [colmix_pkg::pxl_w-1:0]    obj_pxl,
    input  logic [3:0]                      gfx_en,

    output logic [colmix_pkg::pxl_w-1:0]    red,
    output logic [colmix_pkg::pxl_w-1:0]    green,
    output logic [colmix_pkg::pxl_w-1:0]    blue,
    output logic                            lhbl_dly,
    output logic                            lvbl_dly
);

    localparam int pw = colmix_pkg::pxl_w;
    localparam int sel_prisel_hi = colmix_pkg::sel_prisel_lo + colmix_pkg::prisel_w - 1;

    logic [colmix_pkg::prom_aw-1:0] sel_nx;
    logic [colmix_pkg::prom_aw-1:0] seladdr;
    logic [colmix_pkg::prom_dw-1:0] selbus;
    logic [pw-1:0]                  ba0_q, ba1_q, ba2_q, obj_q;
    logic                           lhbl_q, lvbl_q;
    logic [1:0]                     cen_sr;
    logic [colmix_pkg::pal_aw-1:0]  pal_addr;
    logic [1:0]                     we_gr;
    logic                           we_b;
    logic [15:0]                    cpu_gr, vid_gr;
    logic [7:0]                     cpu_b, vid_b;
    logic [colmix_pkg::rgb_w-1:0]   rgb_dly;

    // cpu write strobes, dsn active low
    assign we_gr = ~dsn & {2{pal_cs[0]}};
    assign we_b  = ~dsn[0] & pal_cs[1];
    // blue reads back with the upper byte set
    assign cpu_din = pal_cs[0] ? cpu_gr : {8'hff, cpu_b};

    // priority address fields
    always_comb begin
        sel_nx = '0;
        sel_nx[sel_prisel_hi:colmix_pkg::sel_prisel_lo] = prisel;
        sel_nx[colmix_pkg::sel_ba0_tr]  = ~|ba0_pxl[3:0] | ~gfx_en[0];
        sel_nx[colmix_pkg::sel_obj_msb] = obj_pxl[7];
        sel_nx[colmix_pkg::sel_obj_tr]  = ~|obj_pxl[3:0] | ~gfx_en[3];
        sel_nx[colmix_pkg::sel_ba1_msb] = ba1_pxl[7];
        sel_nx[colmix_pkg::sel_ba1_b3]  = ba1_pxl[3];
        sel_nx[colmix_pkg::sel_ba1_tr]  = ~|ba1_pxl[3:0] | ~gfx_en[1];
        // ba2 needs bit 7 clear as well
        sel_nx[colmix_pkg::sel_ba2_tr]  = (~ba2_pxl[7] & ~|ba2_pxl[2:0]) | ~gfx_en[2];
    end

    // sample address and pixels together at the pixel enable
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            seladdr <= sel_nx;
            ba0_q   <= ba0_pxl;
            ba1_q   <= ba1_pxl;
            ba2_q   <= ba2_pxl;
            obj_q   <= obj_pxl;
        end
    end

    // blanking sampled with its pixel
    // enable pipeline, index loads two clks after pxl_cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_q <= 1'b0;
            lvbl_q <= 1'b0;
            cen_sr <= '0;
        end else begin
            cen_sr <= {cen_sr[0], pxl_cen};
            if (pxl_cen) begin
                lhbl_q <= lhbl;
                lvbl_q <= lvbl;
            end
        end
    end

    // opaque object wins over the prom choice
    always_ff @(posedge clk) begin
        if (cen_sr[1]) begin
            if (obj_q[3:0] != 4'd0) begin
                pal_addr <= {colmix_pkg::layer_obj, obj_q};
            end else begin
                case (selbus)
                    colmix_pkg::layer_ba0: pal_addr <= {selbus, ba0_q};
                    colmix_pkg::layer_obj: pal_addr <= {selbus, obj_q};
                    colmix_pkg::layer_ba1: pal_addr <= {selbus, ba1_q};
                    default:               pal_addr <= {selbus, ba2_q};
                endcase
            end
        end
    end

    prio_prom prio_prom_i (
        .clk     (clk),
        .rd_addr (seladdr),
        .wr_addr (prog_addr),
        .wr_data (prom_din),
        .we      (prom_we),
        .q       (selbus)
    );

    pal_ram pal_ram_i (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_dout),
        .we_gr    (we_gr),
        .we_b     (we_b),
        .cpu_gr   (cpu_gr),
        .cpu_b    (cpu_b),
        .vid_addr (pal_addr),
        .vid_gr   (vid_gr),
        .vid_b    (vid_b)
    );

    // packed as green, red, blue
    blank_delay blank_delay_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl_q),
        .lvbl     (lvbl_q),
        .rgb_in   ({vid_gr, vid_b}),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .rgb_out  (rgb_dly)
    );

    assign green = rgb_dly[3*pw-1:2*pw];
    assign red   = rgb_dly[2*pw-1:pw];
    assign blue  = rgb_dly[pw-1:0];

endmodule

/* sim/colmix_chk.sv */
// colour mixer output checks
`timescale 1ns/1ns

module colmix_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        lhbl_dly,
    input logic        lvbl_dly,
    input logic [7:0]  red,
    input logic [7:0]  green,
    input logic [7:0]  blue,
    input logic [1:0]  pal_cs,
    input logic [15:0] cpu_din
);

    // outputs settle on the rising edge, sampled half a clk later
    blank_in_reset: assert property (@(negedge clk)
        !rst_n |-> (!lhbl_dly && !lvbl_dly))
        else $error("blanking outputs high while reset is held");

    // black whenever either blank is active
    black_when_blank: assert property (@(negedge clk)
        (!lhbl_dly || !lvbl_dly) |-> (red == 8'd0 && green == 8'd0 && blue == 8'd0))
        else $error("colour not zero during blanking");

    // blue readback pads the upper byte
    blue_read_pad: assert property (@(negedge clk)
        (pal_cs == 2'b10) |-> (cpu_din[15:8] == 8'hff))
        else $error("upper byte of blue readback is not ff");

endmodule

bind colmix colmix_chk colmix_chk_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .lhbl_dly (lhbl_dly),
    .lvbl_dly (lvbl_dly),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .pal_cs   (pal_cs),
    .cpu_din  (cpu_din)
);

/* sim/colmix_tb.sv */
// colour mixer testbench
`timescale 1ns/1ns

module colmix_tb;

    localparam int clk_period = 8;
    localparam int pal_depth  = 2 ** colmix_pkg::pal_aw;
    localparam int prom_depth = 2 ** colmix_pkg::prom_aw;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        lhbl, lvbl;
    logic [1:0]  pal_cs;
    logic [9:0]  cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic [15:0] cpu_din;
    logic [colmix_pkg::prisel_w-1:0] prisel;
    logic [colmix_pkg::prom_aw-1:0]  prog_addr;
    logic [colmix_pkg::prom_dw-1:0]  prom_din;
    logic        prom_we;
    logic [7:0]  ba0_pxl, ba1_pxl, ba2_pxl, obj_pxl;
    logic [3:0]  gfx_en;
    logic [7:0]  red, green, blue;
    logic        lhbl_dly, lvbl_dly;

    // shadow memories
    logic [15:0] gr_sh   [pal_depth];
    logic [7:0]  b_sh    [pal_depth];
    logic [1:0]  prom_sh [prom_depth];

    // prisel gfx_en ba0 ba1 ba2 obj lhbl lvbl index, msb first
    logic [50:0] stim_q [$];
    // lhbl, lvbl and palette index due at each pixel pulse
    logic [11:0] exp_q [$];

    logic [31:0] lfsr_state;
    int          err_read, err_stim, err_reset, err_video;
    int          stim_count;
    int          pulse_no;

    colmix colmix_i (
        .clk(clk), .rst_n(rst_n), .pxl_cen(pxl_cen), .lhbl(lhbl), .lvbl(lvbl),
        .pal_cs(pal_cs), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .dsn(dsn),
        .cpu_din(cpu_din), .prisel(prisel), .prog_addr(prog_addr),
        .prom_din(prom_din), .prom_we(prom_we), .ba0_pxl(ba0_pxl),
        .ba1_pxl(ba1_pxl), .ba2_pxl(ba2_pxl), .obj_pxl(obj_pxl), .gfx_en(gfx_en),
        .red(red), .green(green), .blue(blue),
        .lhbl_dly(lhbl_dly), .lvbl_dly(lvbl_dly)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    c [9];
        string line;
        fd = $fopen("sim/colmix_stim.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // skip comments and empty lines
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h %h %h %h %h %h", c[0], c[1], c[2],
                            c[3], c[4], c[5], c[6], c[7], c[8]) == 9) begin
                    stim_q.push_back({c[0][2:0], c[1][3:0], c[2][7:0], c[3][7:0],
                                      c[4][7:0], c[5][7:0], c[6][0], c[7][0],
                                      c[8][9:0]});
                end
            end
            $fclose(fd);
        end
        stim_count = stim_q.size();
    endtask

    // palette index from the override and priority rules
    function automatic logic [9:0] model_index(input logic [50:0] line);
        logic [2:0] p;
        logic [3:0] g;
        logic [7:0] b0, b1, b2, ob;
        logic [9:0] pa;
        {p, g, b0, b1, b2, ob} = line[50:12];
        if (ob[3:0] != 4'd0) begin
            return {colmix_pkg::layer_obj, ob};
        end
        pa = {p, (b0[3:0] == 4'd0) || !g[0], ob[7], (ob[3:0] == 4'd0) || !g[3],
              b1[7], b1[3], (b1[3:0] == 4'd0) || !g[1],
              (!b2[7] && b2[2:0] == 3'd0) || !g[2]};
        case (prom_sh[pa])
            colmix_pkg::layer_ba0: return {prom_sh[pa], b0};
            colmix_pkg::layer_obj: return {prom_sh[pa], ob};
            colmix_pkg::layer_ba1: return {prom_sh[pa], b1};
            default:               return {prom_sh[pa], b2};
        endcase
    endfunction

    task automatic pal_write(input logic [1:0] cs, input logic [9:0] addr,
                             input logic [15:0] data, input logic [1:0] be_n);
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= addr;
        cpu_dout <= data;
        dsn      <= be_n;
        // red low byte, green high byte, blue on dsn[0]
        if (cs[0] && !be_n[0]) begin
            gr_sh[addr][7:0] = data[7:0];
        end
        if (cs[0] && !be_n[1]) begin
            gr_sh[addr][15:8] = data[15:8];
        end
        if (cs[1] && !be_n[0]) begin
            b_sh[addr] = data[7:0];
        end
    endtask

    task automatic cpu_idle();
        @(posedge clk);
        pal_cs <= 2'b00;
        dsn    <= 2'b11;
    endtask

    task automatic pal_read_check(input logic [1:0] cs, input logic [9:0] addr);
        logic [15:0] expected;
        @(posedge clk);
        pal_cs   <= cs;
        cpu_addr <= addr;
        dsn      <= 2'b11;
        // read data registered one clk after the address
        @(posedge clk);
        @(negedge clk);
        expected = cs[0] ? gr_sh[addr] : {8'hff, b_sh[addr]};
        assert (cpu_din === expected) else begin
            $display("Mismatch at %0t: palette read cs %b addr %03h got %04h expected %04h",
                     $time, cs, addr, cpu_din, expected);
            err_read++;
        end
    endtask

    task automatic load_prom();
        logic [3:0] sum;
        logic [9:0] a10;
        for (int a = 0; a < prom_depth; a++) begin
            a10 = 10'(a);
            // scene select plus ba1 and ba2 transparency, modulo 4
            sum = {1'b0, a10[9:7]} + {2'b00, a10[1:0]};
            prom_sh[a] = sum[1:0];
            @(posedge clk);
            prom_we   <= 1'b1;
            prog_addr <= a10;
            prom_din  <= sum[1:0];
        end
        @(posedge clk);
        prom_we <= 1'b0;
    endtask

    task automatic load_palette();
        logic [15:0] data;
        for (int a = 0; a < pal_depth; a++) begin
            take_bits(16, data);
            pal_write(2'b01, 10'(a), data, 2'b00);
            take_bits(8, data);
            pal_write(2'b10, 10'(a), data, 2'b00);
        end
        cpu_idle();
    endtask

    // every dsn pattern on a few random words
    task automatic palette_readback();
        logic [15:0] addr_bits;
        logic [15:0] data;
        for (int k = 0; k < 6; k++) begin
            take_bits(10, addr_bits);
            for (int pat = 0; pat < 4; pat++) begin
                take_bits(16, data);
                pal_write(2'b01, addr_bits[9:0], data, 2'(pat));
                take_bits(8, data);
                pal_write(2'b10, addr_bits[9:0], data, 2'(pat));
                pal_read_check(2'b01, addr_bits[9:0]);
                pal_read_check(2'b10, addr_bits[9:0]);
            end
            pal_read_check(2'b00, addr_bits[9:0]);
        end
        cpu_idle();
    endtask

    task automatic check_stim_indices();
        foreach (stim_q[i]) begin
            assert (model_index(stim_q[i]) == stim_q[i][9:0]) else begin
                $display("Mismatch at %0t: stimulus line %0d expects index %03h, rules give %03h",
                         $time, i, stim_q[i][9:0], model_index(stim_q[i]));
                err_stim++;
            end
        end
    endtask

    task automatic check_reset_outputs();
        @(negedge clk);
        assert ({lhbl_dly, lvbl_dly, red, green, blue} === 26'd0) else begin
            $display("Mismatch at %0t: outputs not blanked before first pixel, %b%b %02h%02h%02h",
                     $time, lhbl_dly, lvbl_dly, red, green, blue);
            err_reset++;
        end
    endtask

    task automatic pixel_pulse(input logic [50:0] line);
        logic [11:0] exp;
        logic [23:0] exp_rgb;
        @(posedge clk);
        pxl_cen <= 1'b1;
        {prisel, gfx_en, ba0_pxl, ba1_pxl, ba2_pxl, obj_pxl, lhbl, lvbl} <= line[50:10];
        exp_q.push_back(line[11:0]);
        @(posedge clk);
        pxl_cen <= 1'b0;
        @(negedge clk);
        // result of the pixel two pulses back
        exp = exp_q.pop_front();
        // green, red, blue; black while blanked
        exp_rgb = (exp[11] && exp[10]) ? {gr_sh[exp[9:0]], b_sh[exp[9:0]]} : 24'd0;
        assert (lhbl_dly === exp[11] && lvbl_dly === exp[10]) else begin
            $display("Mismatch at %0t: pulse %0d blanking got %b%b expected %b%b",
                     $time, pulse_no, lhbl_dly, lvbl_dly, exp[11], exp[10]);
            err_video++;
        end
        assert ({green, red, blue} === exp_rgb) else begin
            $display("Mismatch at %0t: pulse %0d index %03h colour got %02h%02h%02h exp %06h",
                     $time, pulse_no, exp[9:0], green, red, blue, exp_rgb);
            err_video++;
        end
        pulse_no++;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_video();
        // reset state drains out first
        exp_q.push_back(12'd0);
        exp_q.push_back(12'd0);
        foreach (stim_q[i]) begin
            pixel_pulse(stim_q[i]);
        end
        // blanked pixels push the last lines out
        repeat (2) pixel_pulse(51'd0);
    endtask

    // watchdog
    initial begin
        int limit_cycles;
        wait (stim_count > 0);
        // reset, prom, palette, readback, pixel pulses, margin
        limit_cycles = 10 + prom_depth + 2 * pal_depth + 400 + (stim_count + 4) * 4 + 500;
        #(limit_cycles * clk_period);
        fail_run($sformatf("watchdog timeout after %0d clock cycles", limit_cycles));
    end

    initial begin
        rst_n = 1'b0;
        pxl_cen = 1'b0;
        {lhbl, lvbl} = 2'b00;
        pal_cs = 2'b00;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn = 2'b11;
        prisel = '0;
        prog_addr = '0;
        prom_din = '0;
        prom_we = 1'b0;
        {ba0_pxl, ba1_pxl, ba2_pxl, obj_pxl} = '0;
        gfx_en = 4'hf;
        lfsr_state = 32'hdced_67a1;
        {err_read, err_stim, err_reset, err_video} = '0;
        stim_count = 0;
        pulse_no = 0;
        load_stimulus();
        if (stim_count == 0) begin
            fail_run("no stimulus lines read from sim/colmix_stim.txt");
        end else begin
            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            check_reset_outputs();
            load_prom();
            load_palette();
            palette_readback();
            check_stim_indices();
            // still no pixel pulse so far
            check_reset_outputs();
            run_video();
            $display("error counts: readback %0d, stimulus %0d, reset %0d, video %0d",
                     err_read, err_stim, err_reset, err_video);
            if (err_read + err_stim + err_reset + err_video == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

/* sim/colmix_stim.txt */
# hex columns: prisel gfx_en ba0 ba1 ba2 obj lhbl lvbl expected_index
# index is the layer code above the chosen 8-bit pixel
# opaque object overrides the prom
0 f 12 34 56 05 1 1 105
3 f a1 b2 c3 7e 1 1 17e
5 f 00 00 00 f1 1 1 1f1
2 7 44 55 66 89 1 1 189
6 f 0f 09 81 2c 1 1 12c
1 0 33 44 55 0a 1 1 10a
0 f 11 21 31 00 1 1 011
1 f 11 21 31 00 1 1 100
2 f 11 21 31 00 1 1 221
3 f 11 21 31 00 1 1 331
4 f 11 21 31 f0 1 1 011
5 f 22 43 65 30 1 1 130
6 f 22 43 65 80 1 1 243
7 f 22 43 65 00 1 1 365
0 f 5a 40 31 00 1 1 240
0 f 5a 21 00 00 1 1 100
0 f 5a 40 00 00 1 1 300
1 f 5a 40 00 00 1 1 05a
2 f 5a 40 00 00 1 1 100
3 f 77 10 88 40 1 1 140
7 f 77 10 08 00 1 1 210
6 f 77 13 08 00 1 1 308
4 f 9c 00 80 00 1 1 200
0 d 11 21 31 00 1 1 221
0 b 11 21 31 00 1 1 100
0 9 11 21 31 00 1 1 331
1 9 11 21 31 00 1 1 011
2 e 11 21 31 00 1 1 221
3 7 11 21 31 00 1 1 331
5 f 11 21 31 00 1 1 100
5 b 11 21 31 00 1 1 221
5 d 11 21 31 00 1 1 331
0 f 11 21 31 00 0 1 011
1 f 11 21 31 05 1 0 105
2 f 11 21 31 00 0 0 221
3 f 11 21 31 00 1 1 331
4 f 22 43 65 0c 0 1 10c
5 f 22 43 65 00 1 1 100
6 f ee dd cc 00 1 1 2dd
7 f ee dd cc 00 1 1 3cc
0 f ee dd cc 00 1 1 0ee
2 f ee dd cc ff 1 1 1ff

/* sources.f */
design/colmix_pkg.sv
design/prio_prom.sv
design/pal_ram.sv
design/blank_delay.sv
design/colmix.sv
sim/colmix_chk.sv
sim/colmix_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the colour mixer testbench
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module colmix_tb -f sources.f -o colmix_sim \
    && ./obj_dir/colmix_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
